// File: include/uart_bridge_macros.svh
`ifndef UART_BRIDGE_MACROS_SVH
`define UART_BRIDGE_MACROS_SVH

// Clock cycles per serial bit
// 16 keeps simulation short
// 434 gives 115200 baud from the 50 MHz clock
`define UART_CLKS_PER_BIT 16

// Half a bit period, for start bit validation
`define UART_HALF_BIT (`UART_CLKS_PER_BIT / 2)

// Bit timer width
// Nine bits cover the 434 cycle setting
`define UART_CNT_W 9

// Register bank depth, one entry per address
`define REG_DEPTH 256

`endif

// File: hw/uart_bridge_pkg.sv
package uart_bridge_pkg;

	// One byte on the serial line
	typedef logic [7:0] byte_t;

	// Register bank address and contents
	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Receiver bit phases
	typedef enum logic [1:0] {
		rx_st_idle,
		rx_st_start,
		rx_st_data,
		rx_st_stop
	} rx_state_t;

	// Frame decoder steps, one per byte then bus and reply
	typedef enum logic [2:0] {
		fr_wait_cmd,
		fr_wait_addr,
		fr_wait_data,
		fr_bus_req,
		fr_wait_tx
	} frame_state_t;

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/1ns
`include "uart_bridge_macros.svh"

module uart_rx (
	input  logic                   CLK_50MHZ,
	input  logic                   rst_n,
	input  logic                   rx,
	output uart_bridge_pkg::byte_t rx_data,
	output logic                   rx_valid
);
	import uart_bridge_pkg::*;

	// Last count of a full bit and of half a bit
	localparam logic [`UART_CNT_W-1:0] bit_last  = `UART_CNT_W'(`UART_CLKS_PER_BIT - 1);
	localparam logic [`UART_CNT_W-1:0] half_last = `UART_CNT_W'(`UART_HALF_BIT - 1);

	logic                   rx_meta;
	logic                   rx_sync;
	rx_state_t              state;
	logic [`UART_CNT_W-1:0] clk_cnt;
	logic [2:0]             bit_idx;
	logic                   bit_tick;

	// Two flop synchronizer, idle line is high
	always_ff @(posedge CLK_50MHZ or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// Mid-bit sample point for data and stop bits
	assign bit_tick = (clk_cnt == bit_last);

	//////////////////////////////////////////////////////////////////////
	// Bit phase state machine
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_50MHZ or negedge rst_n) begin
		if (!rst_n) begin
			state    <= rx_st_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				rx_st_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// Falling edge, possible start bit
					if (!rx_sync)
						state <= rx_st_start;
				end
				rx_st_start: begin
					if (clk_cnt == half_last) begin
						clk_cnt <= '0;
						// Still low at half a bit, otherwise a glitch
						state   <= rx_sync ? rx_st_idle : rx_st_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_st_data: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_st_stop;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_st_stop: begin
					if (bit_tick) begin
						clk_cnt  <= '0;
						// Low stop bit drops the byte
						rx_valid <= rx_sync;
						state    <= rx_st_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= rx_st_idle;
			endcase
		end
	end

	// Data shift, LSB arrives first
	always_ff @(posedge CLK_50MHZ) begin
		if (state == rx_st_data && bit_tick)
			rx_data <= {rx_sync, rx_data[7:1]};
	end

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ns
`include "uart_bridge_macros.svh"

module uart_tx (
	input  logic                   CLK_50MHZ,
	input  logic                   rst_n,
	input  logic                   tx_start,
	input  uart_bridge_pkg::byte_t tx_data,
	output logic                   tx,
	output logic                   tx_busy
);

	// Last cycle of one bit period
	localparam logic [`UART_CNT_W-1:0] bit_last = `UART_CNT_W'(`UART_CLKS_PER_BIT - 1);

	// Stop, data LSB first, start; bit 0 is on the line
	logic [9:0]             frame_q;
	logic [`UART_CNT_W-1:0] clk_cnt;
	logic [3:0]             bit_cnt;

	// Line driven straight from a flop
	assign tx = frame_q[0];

	//////////////////////////////////////////////////////////////////////
	// Frame load and shift
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_50MHZ or negedge rst_n) begin
		if (!rst_n) begin
			frame_q <= '1;
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			clk_cnt <= '0;
			bit_cnt <= '0;
			// Start bit goes out in the next cycle
			if (tx_start) begin
				frame_q <= {1'b1, tx_data, 1'b0};
				tx_busy <= 1'b1;
			end
		end else if (clk_cnt == bit_last) begin
			clk_cnt <= '0;
			// Idle ones fill in from the top
			frame_q <= {1'b1, frame_q[9:1]};
			// Done after the stop bit, ten bits in all
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

// File: hw/frame_decoder.sv
`timescale 1ns/1ns

module frame_decoder (
	input  logic                       CLK_50MHZ,
	input  logic                       rst_n,
	input  uart_bridge_pkg::byte_t     rx_data,
	input  logic                       rx_valid,
	input  logic                       dec_grant,
	input  uart_bridge_pkg::reg_data_t bank_rdata,
	input  logic                       tx_busy,
	output logic                       dec_req,
	output logic                       dec_we,
	output uart_bridge_pkg::reg_addr_t dec_addr,
	output uart_bridge_pkg::reg_data_t dec_wdata,
	output logic                       tx_start,
	output uart_bridge_pkg::byte_t     tx_data
);
	import uart_bridge_pkg::*;

	frame_state_t state;
	// Command bit 0, set for a read
	logic         cmd_rd;
	// Bank read data lands this cycle
	logic         rd_cap;

	//////////////////////////////////////////////////////////////////////
	// Frame sequencing
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_50MHZ or negedge rst_n) begin
		if (!rst_n) begin
			state  <= fr_wait_cmd;
			cmd_rd <= 1'b0;
			rd_cap <= 1'b0;
		end else begin
			rd_cap <= 1'b0;
			case (state)
				fr_wait_cmd: begin
					if (rx_valid) begin
						cmd_rd <= rx_data[0];
						state  <= fr_wait_addr;
					end
				end
				fr_wait_addr: begin
					if (rx_valid)
						state <= fr_wait_data;
				end
				fr_wait_data: begin
					if (rx_valid)
						state <= fr_bus_req;
				end
				fr_bus_req: begin
					// Write ends here, read goes on to the reply
					if (dec_grant) begin
						rd_cap <= cmd_rd;
						state  <= cmd_rd ? fr_wait_tx : fr_wait_cmd;
					end
				end
				fr_wait_tx: begin
					if (tx_start)
						state <= fr_wait_cmd;
				end
				default: state <= fr_wait_cmd;
			endcase
		end
	end

	// Request held until the grant pulse
	assign dec_req = (state == fr_bus_req);
	assign dec_we  = ~cmd_rd;

	// Reply once captured and the line is free
	assign tx_start = (state == fr_wait_tx) & ~rd_cap & ~tx_busy;

	// Address, data and reply byte
	always_ff @(posedge CLK_50MHZ) begin
		if (rx_valid && state == fr_wait_addr)
			dec_addr <= rx_data;
		// Read frames carry a don't-care data byte
		if (rx_valid && state == fr_wait_data)
			dec_wdata <= rx_data;
		if (rd_cap)
			tx_data <= bank_rdata;
	end

endmodule

// File: hw/reg_arbiter.sv
`timescale 1ns/1ns

module reg_arbiter (
	input  logic                       CLK_50MHZ,
	input  logic                       rst_n,
	input  logic                       dec_req,
	input  logic                       dec_we,
	input  uart_bridge_pkg::reg_addr_t dec_addr,
	input  uart_bridge_pkg::reg_data_t dec_wdata,
	input  logic                       local_req,
	input  logic                       local_we,
	input  uart_bridge_pkg::reg_addr_t local_addr,
	input  uart_bridge_pkg::reg_data_t local_wdata,
	output logic                       dec_grant,
	output logic                       local_grant,
	output logic                       bank_en,
	output logic                       bank_we,
	output uart_bridge_pkg::reg_addr_t bank_addr,
	output uart_bridge_pkg::reg_data_t bank_wdata
);

	// Local port took the last transaction
	logic last_local;

	// Round robin, loser of the last tie goes first
	assign dec_grant   = dec_req & (~local_req | last_local);
	assign local_grant = local_req & (~dec_req | ~last_local);

	// One transaction per cycle whenever anyone asks
	assign bank_en    = dec_req | local_req;
	assign bank_we    = local_grant ? local_we    : dec_we;
	assign bank_addr  = local_grant ? local_addr  : dec_addr;
	assign bank_wdata = local_grant ? local_wdata : dec_wdata;

	// Winner history
	always_ff @(posedge CLK_50MHZ or negedge rst_n) begin
		if (!rst_n)
			last_local <= 1'b0;
		else if (bank_en)
			last_local <= local_grant;
	end

endmodule

// File: hw/reg_bank.sv
`timescale 1ns/1ns
`include "uart_bridge_macros.svh"

module reg_bank (
	input  logic                       CLK_50MHZ,
	input  logic                       bank_en,
	input  logic                       bank_we,
	input  uart_bridge_pkg::reg_addr_t bank_addr,
	input  uart_bridge_pkg::reg_data_t bank_wdata,
	output uart_bridge_pkg::reg_data_t bank_rdata
);
	import uart_bridge_pkg::*;

	// Register storage
	reg_data_t mem [`REG_DEPTH];

	// Write, or registered read one cycle after enable
	always_ff @(posedge CLK_50MHZ) begin
		if (bank_en) begin
			if (bank_we)
				mem[bank_addr] <= bank_wdata;
			else
				bank_rdata <= mem[bank_addr];
		end
	end

endmodule

// File: hw/uart_reg_bridge.sv
`timescale 1ns/1ns

module uart_reg_bridge (
	input  logic                       CLK_50MHZ,
	input  logic                       rst_n,
	input  logic                       rx,
	input  logic                       local_req,
	input  logic                       local_we,
	input  uart_bridge_pkg::reg_addr_t local_addr,
	input  uart_bridge_pkg::reg_data_t local_wdata,
	output logic                       tx,
	output logic                       local_grant,
	output uart_bridge_pkg::reg_data_t local_rdata
);
	import uart_bridge_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////////////////////////
	// Receiver side
	byte_t     rx_data;
	logic      rx_valid;
	// Transmitter side
	byte_t     tx_data;
	logic      tx_start;
	logic      tx_busy;
	// Decoder master
	logic      dec_req;
	logic      dec_we;
	logic      dec_grant;
	reg_addr_t dec_addr;
	reg_data_t dec_wdata;
	// Bank port
	logic      bank_en;
	logic      bank_we;
	reg_addr_t bank_addr;
	reg_data_t bank_wdata;
	reg_data_t bank_rdata;

	uart_rx u_rx (
		.CLK_50MHZ (CLK_50MHZ),
		.rst_n     (rst_n),
		.rx        (rx),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid)
	);

	uart_tx u_tx (
		.CLK_50MHZ (CLK_50MHZ),
		.rst_n     (rst_n),
		.tx_start  (tx_start),
		.tx_data   (tx_data),
		.tx        (tx),
		.tx_busy   (tx_busy)
	);

	frame_decoder u_dec (
		.CLK_50MHZ  (CLK_50MHZ),
		.rst_n      (rst_n),
		.rx_data    (rx_data),
		.rx_valid   (rx_valid),
		.dec_grant  (dec_grant),
		.bank_rdata (bank_rdata),
		.tx_busy    (tx_busy),
		.dec_req    (dec_req),
		.dec_we     (dec_we),
		.dec_addr   (dec_addr),
		.dec_wdata  (dec_wdata),
		.tx_start   (tx_start),
		.tx_data    (tx_data)
	);

	// Serial decoder and local port share the bank
	reg_arbiter u_arb (
		.CLK_50MHZ   (CLK_50MHZ),
		.rst_n       (rst_n),
		.dec_req     (dec_req),
		.dec_we      (dec_we),
		.dec_addr    (dec_addr),
		.dec_wdata   (dec_wdata),
		.local_req   (local_req),
		.local_we    (local_we),
		.local_addr  (local_addr),
		.local_wdata (local_wdata),
		.dec_grant   (dec_grant),
		.local_grant (local_grant),
		.bank_en     (bank_en),
		.bank_we     (bank_we),
		.bank_addr   (bank_addr),
		.bank_wdata  (bank_wdata)
	);

	reg_bank u_bank (
		.CLK_50MHZ  (CLK_50MHZ),
		.bank_en    (bank_en),
		.bank_we    (bank_we),
		.bank_addr  (bank_addr),
		.bank_wdata (bank_wdata),
		.bank_rdata (bank_rdata)
	);

	// Valid the cycle after local_grant
	assign local_rdata = bank_rdata;

endmodule

// File: testbench/uart_reg_bridge_chk.sv
`timescale 1ns/1ns

module uart_reg_bridge_chk (
	input logic CLK_50MHZ,
	input logic rst_n,
	input logic tx,
	input logic local_req,
	input logic local_grant,
	input logic dec_grant,
	input logic tx_start,
	input logic tx_busy
);

	// Failed assertion count
	int fail_cnt = 0;

	// Idle line level during reset
	tx_idle_in_reset: assert property (@(posedge CLK_50MHZ) !rst_n |-> tx)
		else begin
			fail_cnt++;
			$error("tx not high while reset is held");
		end

	// Grant only answers a request
	grant_needs_req: assert property (@(posedge CLK_50MHZ) disable iff (!rst_n)
		local_grant |-> local_req)
		else begin
			fail_cnt++;
			$error("local_grant without local_req");
		end

	// One master on the bank per cycle
	one_grant: assert property (@(posedge CLK_50MHZ) disable iff (!rst_n)
		!(local_grant && dec_grant))
		else begin
			fail_cnt++;
			$error("local and decoder granted in the same cycle");
		end

	// Reply start bit on the line
	// in the cycle after tx_start
	start_bit_next: assert property (@(posedge CLK_50MHZ) disable iff (!rst_n)
		tx_start |=> (tx_busy && !tx))
		else begin
			fail_cnt++;
			$error("no start bit on tx after tx_start");
		end

endmodule

// File: testbench/tb_uart_reg_bridge.sv
`timescale 1ns/1ns
`include "uart_bridge_macros.svh"

module tb_uart_reg_bridge;
	import uart_bridge_pkg::*;

	localparam int clk_period = 20;
	localparam int bit_clks = `UART_CLKS_PER_BIT;
	// Timeouts, grant in cycles, the rest in bit times
	localparam int grant_timeout = 8;
	localparam int reply_timeout_bits = 45;
	localparam int poll_timeout_bits = 40;

	logic      CLK_50MHZ;
	logic      rst_n;
	logic      rx;
	logic      local_req;
	logic      local_we;
	reg_addr_t local_addr;
	reg_data_t local_wdata;
	logic      tx;
	logic      local_grant;
	reg_data_t local_rdata;

	// Expected bank contents
	reg_data_t model [`REG_DEPTH];
	integer    seed;
	int        errors;
	int        tests_run;
	int        tests_failed;

	uart_reg_bridge u_dut (
		.CLK_50MHZ   (CLK_50MHZ),
		.rst_n       (rst_n),
		.rx          (rx),
		.local_req   (local_req),
		.local_we    (local_we),
		.local_addr  (local_addr),
		.local_wdata (local_wdata),
		.tx          (tx),
		.local_grant (local_grant),
		.local_rdata (local_rdata)
	);

	// Port and internal checks
	bind uart_reg_bridge uart_reg_bridge_chk u_chk (
		.CLK_50MHZ   (CLK_50MHZ),
		.rst_n       (rst_n),
		.tx          (tx),
		.local_req   (local_req),
		.local_grant (local_grant),
		.dec_grant   (dec_grant),
		.tx_start    (tx_start),
		.tx_busy     (tx_busy)
	);

	initial begin
		CLK_50MHZ = 1'b0;
		forever #(clk_period / 2) CLK_50MHZ = ~CLK_50MHZ;
	end

	////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////
	task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_reg(input string name, input reg_data_t got, input reg_data_t exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Serial side, all calls start and end on a falling edge
	////////////////////////////////////////////////////////////////////
	task automatic serial_send_byte(input byte_t b);
		// Start bit
		rx = 1'b0;
		repeat (bit_clks) @(negedge CLK_50MHZ);
		// Data, LSB first
		for (int i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (bit_clks) @(negedge CLK_50MHZ);
		end
		// Stop bit
		rx = 1'b1;
		repeat (bit_clks) @(negedge CLK_50MHZ);
	endtask

	task automatic serial_send_frame(input byte_t cmd, input reg_addr_t addr, input byte_t data);
		serial_send_byte(cmd);
		serial_send_byte(addr);
		serial_send_byte(data);
	endtask

	task automatic serial_get_byte(input int timeout_bits, output byte_t b, output logic ok);
		int cnt;
		cnt = 0;
		ok = 1'b0;
		b = '0;
		// Hunt for the start bit
		while (tx !== 1'b0 && cnt < timeout_bits * bit_clks) begin
			@(negedge CLK_50MHZ);
			cnt++;
		end
		if (tx !== 1'b0) begin
			errors++;
			$display("no start bit on tx within %0d bit times", timeout_bits);
		end else begin
			// Middle of the start bit
			repeat (bit_clks / 2) @(negedge CLK_50MHZ);
			ok = (tx === 1'b0);
			for (int i = 0; i < 8; i++) begin
				repeat (bit_clks) @(negedge CLK_50MHZ);
				b[i] = tx;
			end
			repeat (bit_clks) @(negedge CLK_50MHZ);
			if (tx !== 1'b1)
				ok = 1'b0;
			if (!ok) begin
				errors++;
				$display("reply on tx at %0t ns has a bad start or stop bit", $time);
			end
		end
	endtask

	// Line must stay high the whole window
	task automatic tx_quiet(input int bits, output logic quiet);
		quiet = 1'b1;
		for (int cnt = 0; cnt < bits * bit_clks; cnt++) begin
			@(negedge CLK_50MHZ);
			if (tx !== 1'b1)
				quiet = 1'b0;
		end
	endtask

	task automatic serial_write(input byte_t cmd, input reg_addr_t addr, input reg_data_t data);
		serial_send_frame({cmd[7:1], 1'b0}, addr, data);
		model[addr] = data;
	endtask

	// Read frame and reply watched in parallel
	task automatic serial_read_check(input byte_t cmd, input reg_addr_t addr, input byte_t filler);
		byte_t got;
		logic  ok;
		fork
			serial_send_frame({cmd[7:1], 1'b1}, addr, filler);
			serial_get_byte(reply_timeout_bits, got, ok);
		join
		if (ok)
			compare_byte($sformatf("tx reply for reg %02h", addr), got, model[addr]);
	endtask

	////////////////////////////////////////////////////////////////////
	// Local port
	////////////////////////////////////////////////////////////////////
	task automatic local_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
			output reg_data_t rdata, output int waits, output logic ok);
		int cnt;
		cnt = 0;
		ok = 1'b0;
		local_req = 1'b1;
		local_we = we;
		local_addr = addr;
		local_wdata = wdata;
		while (!ok && cnt < grant_timeout) begin
			// Combinational grant, look mid low phase
			#(clk_period / 4);
			ok = (local_grant === 1'b1);
			@(negedge CLK_50MHZ);
			if (!ok)
				cnt++;
		end
		waits = cnt;
		// Read data one cycle after the grant
		rdata = local_rdata;
		local_req = 1'b0;
		if (!ok) begin
			errors++;
			$display("local access to %02h not granted within %0d cycles", addr, grant_timeout);
		end else if (we) begin
			model[addr] = wdata;
		end
	endtask

	// Repeated local reads until the value lands
	task automatic local_read_until(input reg_addr_t addr, input reg_data_t exp);
		reg_data_t rd;
		int        waits;
		int        elapsed;
		logic      ok;
		elapsed = 0;
		rd = ~exp;
		while (rd !== exp && elapsed < poll_timeout_bits * bit_clks) begin
			local_access(1'b0, addr, '0, rd, waits, ok);
			elapsed += waits + 1;
		end
		compare_reg($sformatf("local read of reg %02h", addr), rd, exp);
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - start_errors);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////
	task automatic test_serial_write_local_read();
		int        start_errors;
		reg_addr_t addrs [3];
		reg_data_t datas [3];
		start_errors = errors;
		addrs = '{8'h18, 8'h1A, 8'h1B};
		datas = '{8'h03, 8'h5A, 8'hC3};
		for (int i = 0; i < 3; i++) begin
			serial_write(8'h00, addrs[i], datas[i]);
			local_read_until(addrs[i], datas[i]);
		end
		finish_test("serial write, local read", start_errors);
	endtask

	task automatic test_local_write_serial_read();
		int        start_errors;
		reg_data_t rd;
		int        waits;
		logic      ok;
		logic      quiet;
		start_errors = errors;
		local_access(1'b1, 8'h19, 8'hA5, rd, waits, ok);
		serial_read_check(8'h01, 8'h19, 8'h00);
		// Exactly one reply byte
		tx_quiet(20, quiet);
		if (!quiet) begin
			errors++;
			$display("extra byte on tx after the read reply");
		end
		// Write frame gets no reply
		fork
			serial_write(8'h00, 8'h1C, 8'h77);
			tx_quiet(50, quiet);
		join
		if (!quiet) begin
			errors++;
			$display("write frame produced a byte on tx");
		end
		finish_test("local write, serial read", start_errors);
	endtask

	task automatic test_contention();
		int        start_errors;
		reg_data_t ser_data [4];
		reg_data_t rd;
		reg_addr_t addr;
		int        waits;
		int        idx;
		logic      ok;
		logic      serial_done;
		start_errors = errors;
		serial_done = 1'b0;
		idx = 0;
		for (int i = 0; i < 4; i++)
			ser_data[i] = reg_data_t'(8'h31 + i * 8'h11);
		fork
			begin
				for (int i = 0; i < 4; i++)
					serial_write(8'h00, reg_addr_t'(8'h80 + i), ser_data[i]);
				serial_done = 1'b1;
			end
			begin
				// Back to back writes over 40..4F until the frames finish
				while (!serial_done && idx < 2000) begin
					addr = reg_addr_t'(8'h40 + idx % 16);
					local_access(1'b1, addr, reg_data_t'(idx * 37 + 5), rd, waits, ok);
					if (ok && waits > 1) begin
						errors++;
						$display("local port waited %0d cycles for a grant", waits);
					end
					idx++;
				end
			end
		join
		local_read_until(8'h83, ser_data[3]);
		for (int i = 0; i < 20; i++) begin
			addr = (i < 16) ? reg_addr_t'(8'h40 + i) : reg_addr_t'(8'h80 + i - 16);
			local_access(1'b0, addr, '0, rd, waits, ok);
			compare_reg($sformatf("local read of reg %02h", addr), rd, model[addr]);
		end
		finish_test("contention", start_errors);
	endtask

	task automatic test_glitch_reject();
		int start_errors;
		start_errors = errors;
		// Quarter bit low pulse
		rx = 1'b0;
		repeat (bit_clks / 4) @(negedge CLK_50MHZ);
		rx = 1'b1;
		repeat (2 * bit_clks) @(negedge CLK_50MHZ);
		serial_write(8'h00, 8'h2C, 8'h6E);
		local_read_until(8'h2C, 8'h6E);
		// Frame alignment still intact
		serial_read_check(8'h01, 8'h2C, 8'h00);
		finish_test("glitch rejection", start_errors);
	endtask

	task automatic test_random_round_trip();
		int          start_errors;
		logic [31:0] rnd;
		start_errors = errors;
		for (int i = 0; i < 20; i++) begin
			rnd = $random(seed);
			// Upper command bits and read filler are don't-care
			serial_write(rnd[31:24], rnd[7:0], rnd[15:8]);
			serial_read_check(rnd[23:16], rnd[7:0], rnd[31:24]);
		end
		finish_test("random round trips", start_errors);
	endtask

	////////////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////////////
	initial begin
		seed = 32'he4c5;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst_n = 1'b1;
		rx = 1'b1;
		local_req = 1'b0;
		local_we = 1'b0;
		local_addr = '0;
		local_wdata = '0;
		// Reset edge before the first clock
		#1;
		rst_n = 1'b0;
		repeat (8) @(negedge CLK_50MHZ);
		rst_n = 1'b1;
		repeat (2) @(negedge CLK_50MHZ);

		test_serial_write_local_read();
		test_local_write_serial_read();
		test_contention();
		test_glitch_reject();
		test_random_round_trip();

		errors += u_dut.u_chk.fail_cnt;
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
hw/uart_bridge_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/frame_decoder.sv
hw/reg_arbiter.sv
hw/reg_bank.sv
hw/uart_reg_bridge.sv
testbench/uart_reg_bridge_chk.sv
testbench/tb_uart_reg_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_uart_reg_bridge
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
